// File: Makefile
# Verilator build and run for the quad SRAM line reader
# override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_spi_video_ram
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed!

SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := common/svram_defs.svh
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failures, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
+incdir+common
common/svram_pkg.sv
sram_reader/sck_phase_gen.sv
sram_reader/sram_read_sequencer.sv
logic/pixel_serializer.sv
logic/spi_video_ram.sv
verification/spi_video_ram_asserts.sv
verification/tb_spi_video_ram.sv

// File: common/svram_defs.svh
`ifndef SVRAM_DEFS_SVH
`define SVRAM_DEFS_SVH

// 23lc1024 instruction codes actually issued

// sequential read, quad bus after eqio
`define SVRAM_INS_READ 8'h03

// enter quad i/o, sent one bit at a time on sio0
`define SVRAM_INS_EQIO 8'h38

// screen geometry
// visible lines, vpos equal to this marks the frame end
`define SVRAM_SCREEN_HEIGHT 256

// one line is 512 pixels, 1 bit each
`define SVRAM_BYTES_PER_LINE 64

// two nibbles per byte
`define SVRAM_NIBBLES_PER_LINE 128

// read protocol
// one dummy byte in quad mode = two sck clocks
`define SVRAM_DUMMY_NIBBLES 2

// byte address width of the sram command
`define SVRAM_ADDR_WIDTH 24

`endif

// File: common/svram_pkg.sv
`include "svram_defs.svh"

package svram_pkg;

    // sram byte address
    typedef logic [`SVRAM_ADDR_WIDTH-1:0] sram_addr_t;
    // one quad bus transfer
    typedef logic [3:0] nibble_t;
    // instruction byte
    typedef logic [7:0] sram_cmd_t;
    // display h/v coordinate
    typedef logic [9:0] screen_pos_t;
    // holds up to 128 data nibbles
    typedef logic [7:0] nibble_count_t;

    // read sequencer states, quad entry first after reset
    typedef enum logic [2:0] {
        st_set_quad,
        st_idle,
        st_start_line,
        st_send_ins,
        st_send_addr,
        st_dummy,
        st_read_line
    } seq_state_e;

    // divider outputs; strobe = second high cycle of the quarter phase
    typedef struct packed {
        logic half;
        logic quarter;
        logic capture_strobe;
    } sck_phase_s;

    // one sampled data nibble
    typedef struct packed {
        logic    valid;
        nibble_t data;
    } capture_s;

    // everything going to the sram pins
    typedef struct packed {
        logic    cs_n;
        logic    sck;
        logic    oe;
        nibble_t sio;
    } sram_pins_s;

endpackage

// File: logic/pixel_serializer.sv
module pixel_serializer (
    input  logic                    clk,
    input  logic                    reset,
    input  svram_pkg::capture_s     capture_i,
    input  svram_pkg::screen_pos_t  hpos_i,
    output logic                    pixel_o
);
    import svram_pkg::*;

    // most recent nibble from the sram
    nibble_t   nibble_q;
    // bit of the nibble for this pixel
    logic [1:0] bit_sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            nibble_q <= '0;
        end else if (capture_i.valid) begin
            nibble_q <= capture_i.data;
        end
    end

    // leftmost pixel is the msb
    // hpos 00 -> bit 3 ... 11 -> bit 0
    assign bit_sel = 2'd3 - hpos_i[1:0];

    assign pixel_o = nibble_q[bit_sel];

endmodule

// File: logic/spi_video_ram.sv
module spi_video_ram (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    display_trigger_read_i,
    input  svram_pkg::screen_pos_t  display_hpos_i,
    input  svram_pkg::screen_pos_t  display_vpos_i,
    input  svram_pkg::nibble_t      sram_sio_i,
    output svram_pkg::sram_pins_s   sram_o,
    output logic                    pixel_o
);
    import svram_pkg::*;

    // stage 1 -> stage 2
    sck_phase_s phase;
    logic       sck;

    // stage 2 -> stage 1
    logic       read_start;
    logic       in_read_line;

    // stage 2 pin fields
    logic       cs_n;
    logic       sio_oe;
    nibble_t    sio_out;

    // stage 2 -> stage 3
    capture_s   capture;

    // sck dividers and sck source
    sck_phase_gen u_sck_phase_gen (
        .clk            (clk),
        .reset          (reset),
        .read_start_i   (read_start),
        .in_read_line_i (in_read_line),
        .phase_o        (phase),
        .sck_o          (sck)
    );

    // quad entry, command and address, data capture
    sram_read_sequencer u_sram_read_sequencer (
        .clk            (clk),
        .reset          (reset),
        .trigger_read_i (display_trigger_read_i),
        .vpos_i         (display_vpos_i),
        .phase_i        (phase),
        .sio_i          (sram_sio_i),
        .read_start_o   (read_start),
        .in_read_line_o (in_read_line),
        .cs_n_o         (cs_n),
        .sio_oe_o       (sio_oe),
        .sio_o          (sio_out),
        .capture_o      (capture)
    );

    // nibble latch and bit select
    pixel_serializer u_pixel_serializer (
        .clk       (clk),
        .reset     (reset),
        .capture_i (capture),
        .hpos_i    (display_hpos_i),
        .pixel_o   (pixel_o)
    );

    // pin bundle for the pad ring
    assign sram_o.cs_n = cs_n;
    assign sram_o.sck  = sck;
    assign sram_o.oe   = sio_oe;
    assign sram_o.sio  = sio_out;

endmodule

// File: sram_reader/sck_phase_gen.sv
module sck_phase_gen (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    read_start_i,
    input  logic                    in_read_line_i,
    output svram_pkg::sck_phase_s   phase_o,
    output logic                    sck_o
);
    import svram_pkg::*;

    // clk/2 and clk/4 dividers
    logic half_q;
    logic quarter_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            half_q    <= 1'b0;
            quarter_q <= 1'b0;
        end else if (read_start_i) begin
            // restart both so the read begins on a known phase
            half_q    <= 1'b0;
            quarter_q <= 1'b0;
        end else begin
            half_q <= ~half_q;
            // quarter flips together with the half rising edge
            if (!half_q) begin
                quarter_q <= ~quarter_q;
            end
        end
    end

    // half high = sequencer step cycle
    assign phase_o.half    = half_q;
    assign phase_o.quarter = quarter_q;
    // quarter sck high for its second clk, data settled here
    assign phase_o.capture_strobe = ~half_q & quarter_q;

    // commands at clk/2, line data at clk/4
    assign sck_o = in_read_line_i ? quarter_q : half_q;

endmodule

// File: sram_reader/sram_read_sequencer.sv
`include "svram_defs.svh"

module sram_read_sequencer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        trigger_read_i,
    input  svram_pkg::screen_pos_t      vpos_i,
    input  svram_pkg::sck_phase_s       phase_i,
    input  svram_pkg::nibble_t          sio_i,
    output logic                        read_start_o,
    output logic                        in_read_line_o,
    output logic                        cs_n_o,
    output logic                        sio_oe_o,
    output svram_pkg::nibble_t          sio_o,
    output svram_pkg::capture_s         capture_o
);
    import svram_pkg::*;

    localparam sram_cmd_t INS_READ = `SVRAM_INS_READ;
    localparam sram_cmd_t INS_EQIO = `SVRAM_INS_EQIO;
    localparam int BUF_W = `SVRAM_ADDR_WIDTH;

    seq_state_e    state;
    // eqio bit index during quad entry, 8 = done
    logic [3:0]    init_step;
    // top nibble drives sio
    sram_addr_t    out_buf;
    // bits still to send from out_buf
    logic [4:0]    bits_left;
    // dummy clocks, then data nibbles
    nibble_count_t nibble_cnt;
    sram_addr_t    line_addr;
    // accepted trigger waiting for a step cycle
    logic          start_req;

    logic          trigger_accept;
    logic          last_nibble;

    // only idle, no pending request, visible line
    assign trigger_accept = trigger_read_i
                          && (state == st_idle)
                          && !start_req
                          && (vpos_i < screen_pos_t'(`SVRAM_SCREEN_HEIGHT));

    // realigns the sck dividers in the same clk
    assign read_start_o   = trigger_accept;
    assign in_read_line_o = (state == st_read_line);

    assign sio_o = out_buf[BUF_W-1 -: 4];

    // data sampled straight off the bus on the strobe
    assign capture_o.valid = (state == st_read_line) && phase_i.capture_strobe;
    assign capture_o.data  = sio_i;

    assign last_nibble = (nibble_cnt == nibble_count_t'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_set_quad;
            init_step  <= '0;
            cs_n_o     <= 1'b1;
            sio_oe_o   <= 1'b1;
            // sio3..1 high, keeps hold_n inactive while still in spi mode
            out_buf    <= {4'b1111, {(BUF_W-4){1'b0}}};
            bits_left  <= '0;
            nibble_cnt <= '0;
            line_addr  <= '0;
            start_req  <= 1'b0;
        end else begin
            if (trigger_accept) begin
                start_req <= 1'b1;
            end

            // everything but data capture steps on the half phase
            if (phase_i.half) begin
                case (state)
                    st_set_quad: begin
                        // eqio msb first on sio0, one bit per sck
                        cs_n_o    <= 1'b0;
                        init_step <= init_step + 4'd1;
                        if (init_step == 4'd8) begin
                            cs_n_o <= 1'b1;
                            state  <= st_idle;
                        end else begin
                            out_buf[BUF_W-4] <= INS_EQIO[3'd7 - init_step[2:0]];
                        end
                    end

                    st_idle: begin
                        if (start_req) begin
                            start_req <= 1'b0;
                            state     <= st_start_line;
                        end
                    end

                    st_start_line: begin
                        // select chip, instruction in the top byte
                        cs_n_o    <= 1'b0;
                        out_buf   <= {INS_READ, {(BUF_W-8){1'b0}}};
                        bits_left <= 5'd8;
                        state     <= st_send_ins;
                    end

                    st_send_ins: begin
                        if (bits_left == 5'd4) begin
                            // instruction done, load line address
                            out_buf   <= line_addr;
                            bits_left <= 5'(BUF_W);
                            state     <= st_send_addr;
                        end else begin
                            out_buf   <= out_buf << 4;
                            bits_left <= bits_left - 5'd4;
                        end
                    end

                    st_send_addr: begin
                        if (bits_left == 5'd4) begin
                            // release bus, sram drives after the dummy clocks
                            sio_oe_o   <= 1'b0;
                            nibble_cnt <= nibble_count_t'(`SVRAM_DUMMY_NIBBLES);
                            state      <= st_dummy;
                        end else begin
                            out_buf   <= out_buf << 4;
                            bits_left <= bits_left - 5'd4;
                        end
                    end

                    st_dummy: begin
                        if (last_nibble) begin
                            // sck switches to clk/4 from here
                            nibble_cnt <= nibble_count_t'(`SVRAM_NIBBLES_PER_LINE);
                            state      <= st_read_line;
                        end else begin
                            nibble_cnt <= nibble_cnt - nibble_count_t'(1);
                        end
                    end

                    st_read_line: begin
                        // advanced by the capture strobe below
                    end

                    default: begin
                        state <= st_idle;
                    end
                endcase
            end

            // one data nibble per quarter period
            if (capture_o.valid) begin
                if (last_nibble) begin
                    cs_n_o   <= 1'b1;
                    sio_oe_o <= 1'b1;
                    state    <= st_idle;
                    // next line, or wrap at end of frame
                    if (vpos_i == screen_pos_t'(`SVRAM_SCREEN_HEIGHT)) begin
                        line_addr <= '0;
                    end else begin
                        line_addr <= line_addr + sram_addr_t'(`SVRAM_BYTES_PER_LINE);
                    end
                end else begin
                    nibble_cnt <= nibble_cnt - nibble_count_t'(1);
                end
            end
        end
    end

endmodule

// File: verification/spi_video_ram_asserts.sv
module spi_video_ram_asserts (
    input  logic                    clk,
    input  logic                    reset,
    input  svram_pkg::sram_pins_s   sram_i,
    input  svram_pkg::capture_s     capture_i
);

    // per-property failure tallies
    int unsigned sio_fails   = 0;
    int unsigned oe_fails    = 0;
    int unsigned reset_fails = 0;
    int unsigned cs_fails    = 0;
    int unsigned fail_count;

    assign fail_count = sio_fails + oe_fails + reset_fails + cs_fails;

    // sram samples on sck rising, bus only moves with sck low
    sio_stable_a: assert property (@(posedge clk) disable iff (reset)
        (!sram_i.cs_n && sram_i.sck) |-> $stable(sram_i.sio))
    else begin
        $error("sio outputs changed while cs_n low and sck high");
        sio_fails = sio_fails + 1;
    end

    // no capture while the dut still drives the bus
    capture_oe_a: assert property (@(posedge clk) disable iff (reset)
        capture_i.valid |-> !sram_i.oe)
    else begin
        $error("capture valid with sio output enable high");
        oe_fails = oe_fails + 1;
    end

    reset_cs_a: assert property (@(posedge clk)
        reset |=> sram_i.cs_n)
    else begin
        $error("cs_n not high in the cycle after reset");
        reset_fails = reset_fails + 1;
    end

    // data only inside a selected transaction
    capture_cs_a: assert property (@(posedge clk) disable iff (reset)
        capture_i.valid |-> !sram_i.cs_n)
    else begin
        $error("capture valid with cs_n high");
        cs_fails = cs_fails + 1;
    end

endmodule

bind spi_video_ram spi_video_ram_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .sram_i    (sram_o),
    .capture_i (capture)
);

// File: verification/tb_spi_video_ram.sv
`include "svram_defs.svh"

module tb_spi_video_ram;
    import svram_pkg::*;

    localparam int NUM_ROWS      = 8;
    localparam int INIT_TIMEOUT  = 200;
    localparam int START_TIMEOUT = 64;
    localparam int LINE_TIMEOUT  = 2000;
    // how long a rejected trigger is watched
    localparam int IDLE_WINDOW   = 80;
    localparam sram_cmd_t INS_READ = `SVRAM_INS_READ;
    localparam sram_cmd_t INS_EQIO = `SVRAM_INS_EQIO;

    // trigger vpos, vpos at line end, expected address, expect accept
    typedef struct packed {
        screen_pos_t trig_vpos;
        screen_pos_t end_vpos;
        sram_addr_t  exp_addr;
        logic        exp_accept;
    } row_t;

    row_t rows [NUM_ROWS] = '{
        '{10'd0,   10'd1,   24'd0,   1'b1},
        '{10'd1,   10'd2,   24'd64,  1'b1},
        '{10'd300, 10'd300, 24'd0,   1'b0},
        // frame end, next line wraps to 0
        '{10'd2,   10'd256, 24'd128, 1'b1},
        '{10'd256, 10'd256, 24'd0,   1'b0},
        '{10'd0,   10'd1,   24'd0,   1'b1},
        '{10'd255, 10'd255, 24'd64,  1'b1},
        '{10'd10,  10'd10,  24'd128, 1'b1}
    };

    logic        clk;
    logic        reset;
    logic        trigger;
    screen_pos_t hpos;
    screen_pos_t vpos;
    nibble_t     sio_in = '0;
    sram_pins_s  sram_pins;
    logic        pixel;

    // quad sram model state
    logic        sck_prev;
    logic        cs_prev;
    logic        quad_mode;
    int unsigned edge_cnt;
    logic [7:0]  eqio_shift;
    logic [7:0]  eqio_cmd;
    int unsigned eqio_edges;
    logic        eqio_done;
    sram_cmd_t   rd_cmd;
    sram_addr_t  rd_addr;
    int unsigned read_count;

    int unsigned check_count = 0;
    int unsigned error_count = 0;

    spi_video_ram uut (
        .clk                    (clk),
        .reset                  (reset),
        .display_trigger_read_i (trigger),
        .display_hpos_i         (hpos),
        .display_vpos_i         (vpos),
        .sram_sio_i             (sio_in),
        .sram_o                 (sram_pins),
        .pixel_o                (pixel)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // model data: line number plus nibble index, low 4 bits
    function automatic nibble_t sram_data_nibble(sram_addr_t addr, int unsigned idx);
        sram_addr_t sum;
        sum = addr / sram_addr_t'(`SVRAM_BYTES_PER_LINE) + sram_addr_t'(idx);
        return sum[3:0];
    endfunction

    // sees last cycle's pins, so an sck rise shows as high now, low before
    always @(posedge clk) begin
        if (reset) begin
            sck_prev   <= 1'b0;
            cs_prev    <= 1'b1;
            quad_mode  <= 1'b0;
            edge_cnt   <= 0;
            eqio_done  <= 1'b0;
            read_count <= 0;
        end else begin
            sck_prev <= sram_pins.sck;
            cs_prev  <= sram_pins.cs_n;
            if (!sram_pins.cs_n && sram_pins.sck && !sck_prev) begin
                edge_cnt <= edge_cnt + 1;
                if (!quad_mode) begin
                    // spi mode, one instruction bit on sio0
                    eqio_shift <= {eqio_shift[6:0], sram_pins.sio[0]};
                end else if (edge_cnt < 2) begin
                    rd_cmd <= {rd_cmd[3:0], sram_pins.sio};
                end else if (edge_cnt < 8) begin
                    rd_addr <= {rd_addr[19:0], sram_pins.sio};
                end else if (edge_cnt >= 10) begin
                    // edges 8 and 9 are the dummy clocks
                    sio_in <= sram_data_nibble(rd_addr, edge_cnt - 10);
                end
            end
            // cs_n rising closes a transaction
            if (sram_pins.cs_n && !cs_prev) begin
                edge_cnt <= 0;
                if (!quad_mode) begin
                    eqio_cmd   <= eqio_shift;
                    eqio_edges <= edge_cnt;
                    eqio_done  <= 1'b1;
                    quad_mode  <= 1'b1;
                end else begin
                    read_count <= read_count + 1;
                end
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    // sampled on the falling clk edge, away from dut updates
    task automatic wait_for_cs_n(input logic level, input int limit, output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (sram_pins.cs_n == level) begin
                seen = 1'b1;
            end
        end
    endtask

    task automatic check_pixels(input sram_addr_t line_addr);
        nibble_t     nib;
        logic [31:0] rand_bits;
        // index 127 is the last nibble latched for the line
        nib = sram_data_nibble(line_addr, `SVRAM_NIBBLES_PER_LINE - 1);
        for (int j = 0; j < 4; j++) begin
            rand_bits = $urandom;
            @(posedge clk);
            hpos <= {rand_bits[7:0], 2'(j)};
            @(negedge clk);
            // msb is the leftmost pixel
            check_value("pixel_o", 32'(nib[3 - j]), 32'(pixel));
        end
    endtask

    initial begin : stimulus
        int unsigned errors_before;
        int unsigned reads_before;
        int          cycles;
        logic        seen;
        int unsigned assert_fails;
        void'($urandom(32'h9915bbd0));
        reset   = 1'b1;
        trigger = 1'b0;
        hpos    = '0;
        vpos    = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // quad entry runs on its own after reset
        cycles = 0;
        while (!eqio_done && cycles < INIT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!eqio_done) begin
            report_timeout("quad mode entry never ended with cs_n high");
        end
        check_value("eqio instruction", 32'(INS_EQIO), 32'(eqio_cmd));
        check_value("eqio sck edges", 32'd8, 32'(eqio_edges));
        check_value("sram_o.cs_n", 32'd1, 32'(sram_pins.cs_n));
        check_value("sram_o.oe", 32'd1, 32'(sram_pins.oe));
        $display("test 0 quad entry: %s", (error_count == 0) ? "ok" : "FAILED");

        for (int i = 0; i < NUM_ROWS; i++) begin
            errors_before = error_count;
            reads_before  = read_count;
            @(posedge clk);
            vpos    <= rows[i].trig_vpos;
            trigger <= 1'b1;
            @(posedge clk);
            trigger <= 1'b0;
            if (rows[i].exp_accept) begin
                wait_for_cs_n(1'b0, START_TIMEOUT, seen);
                if (!seen) begin
                    report_timeout("cs_n did not fall after an accepted trigger");
                end else begin
                    // retrigger while busy, must not start another read
                    @(posedge clk);
                    vpos    <= rows[i].end_vpos;
                    trigger <= 1'b1;
                    @(posedge clk);
                    trigger <= 1'b0;
                    wait_for_cs_n(1'b1, LINE_TIMEOUT, seen);
                    if (!seen) begin
                        report_timeout("cs_n did not rise at the end of the line");
                    end
                end
                // model counts the read one cycle after cs_n rises
                repeat (2) @(negedge clk);
                check_value("read count", 32'(reads_before + 1), 32'(read_count));
                check_value("read instruction", 32'(INS_READ), 32'(rd_cmd));
                check_value("line address", 32'(rows[i].exp_addr), 32'(rd_addr));
                check_value("sram_o.oe", 32'd1, 32'(sram_pins.oe));
                check_pixels(rows[i].exp_addr);
                // the busy retrigger leaves no pending start behind
                wait_for_cs_n(1'b0, IDLE_WINDOW, seen);
                check_value("sram_o.cs_n held high", 32'd1, 32'(!seen));
            end else begin
                wait_for_cs_n(1'b0, IDLE_WINDOW, seen);
                check_value("sram_o.cs_n held high", 32'd1, 32'(!seen));
                check_value("read count", 32'(reads_before), 32'(read_count));
            end
            $display("test %0d vpos %0d: %s", i + 1, rows[i].trig_vpos,
                     (error_count == errors_before) ? "ok" : "FAILED");
        end

        assert_fails = uut.u_asserts.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
